/* run.sh */
#!/bin/sh
# Build and run the fdbk_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module fdbk_core_tb -f tb.f \
	--Mdir obj_dir -o fdbk_sim

status=0
./obj_dir/fdbk_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

/* src/fdbk_core.sv */
`timescale 1ns/1ps
`default_nettype none

module fdbk_core import fdbk_pkg::*; (
	input logic clk,
	input logic rst,
	// One cycle in frame_len, lands on an I sample
	input logic sync,
	// High on I samples
	input logic iq,
	input logic signed [data_w-1:0] in_xy,
	input logic [1:0] coarse_scale,
	input logic lb_write,
	input logic [lb_addr_w-1:0] lb_addr,
	input logic signed [data_w-1:0] lb_data,
	output logic signed [data_w-1:0] out_xy
);

	// Register file outputs
	logic signed [data_w-1:0] set_i;
	logic signed [data_w-1:0] set_q;
	logic signed [data_w-1:0] gain_p;
	logic signed [data_w-1:0] gain_i;
	logic signed [data_w-1:0] lim_hi;
	logic signed [data_w-1:0] lim_lo;
	logic int_clr;

	// Slow path
	logic signed [data_w-1:0] avg_i;
	logic signed [data_w-1:0] avg_q;
	logic dec_stb;
	logic signed [data_w-1:0] drive_i;
	logic signed [data_w-1:0] drive_q;
	logic drive_stb;

	// Frame hold output, serialized per sample
	logic signed [data_w-1:0] drive_xy;
	logic signed [data_w-1:0] set_xy;

	fdbk_regs regs (
		.clk(clk), .rst(rst),
		.lb_write(lb_write), .lb_addr(lb_addr), .lb_data(lb_data),
		.set_i(set_i), .set_q(set_q),
		.gain_p(gain_p), .gain_i(gain_i),
		.lim_hi(lim_hi), .lim_lo(lim_lo),
		.int_clr(int_clr)
	);

	// Producer, average then integrate once per frame
	iq_decim decim (
		.clk(clk), .rst(rst), .sync(sync), .iq(iq), .in_xy(in_xy),
		.avg_i(avg_i), .avg_q(avg_q), .dec_stb(dec_stb)
	);

	slow_integ integ (
		.clk(clk), .rst(rst), .dec_stb(dec_stb),
		.avg_i(avg_i), .avg_q(avg_q),
		.set_i(set_i), .set_q(set_q), .gain_i(gain_i),
		.lim_hi(lim_hi), .lim_lo(lim_lo), .int_clr(int_clr),
		.drive_i(drive_i), .drive_q(drive_q), .drive_stb(drive_stb)
	);

	// Buffer, drive changes only at a frame edge
	iq_hold hold (
		.clk(clk), .rst(rst), .sync(sync), .iq(iq),
		.drive_stb(drive_stb), .drive_i(drive_i), .drive_q(drive_q),
		.set_i(set_i), .set_q(set_q),
		.drive_xy(drive_xy), .set_xy(set_xy)
	);

	// Consumer, low-latency proportional loop
	ll_prop prop (
		.clk(clk), .rst(rst), .in_xy(in_xy),
		.set_xy(set_xy), .drive_xy(drive_xy),
		.gain_p(gain_p), .coarse_scale(coarse_scale),
		.out_xy(out_xy)
	);

endmodule

`default_nettype wire

/* src/fdbk_pkg.sv */
`default_nettype none

package fdbk_pkg;

	// Sample, set-point, gain and output word width
	localparam int data_w = 18;
	// Decimator sum of four samples needs two guard bits
	localparam int sum_w = 20;
	// Integrator state width, top data_w bits form the drive
	localparam int acc_w = 24;

	// One frame is four I and four Q samples
	localparam int frame_len = 8;
	localparam int frame_cnt_w = $clog2(frame_len);

	// Local bus
	localparam int lb_addr_w = 3;
	localparam logic [lb_addr_w-1:0] addr_set_i = 3'd0;
	localparam logic [lb_addr_w-1:0] addr_set_q = 3'd1;
	localparam logic [lb_addr_w-1:0] addr_gain_p = 3'd2;
	localparam logic [lb_addr_w-1:0] addr_gain_i = 3'd3;
	localparam logic [lb_addr_w-1:0] addr_lim_hi = 3'd4;
	localparam logic [lb_addr_w-1:0] addr_lim_lo = 3'd5;
	// Write strobe only, no storage behind it
	localparam logic [lb_addr_w-1:0] addr_int_clr = 3'd6;

	// Integral gain scaling
	localparam int ki_shift = 10;
	// Proportional base shift, reduced by coarse_scale
	localparam int kp_shift = 16;
	localparam int kp_shamt_w = $clog2(kp_shift + 1);

	// Output saturation bounds
	localparam logic signed [data_w-1:0] sat_max = 2 ** (data_w - 1) - 1;
	localparam logic signed [data_w-1:0] sat_min = -(2 ** (data_w - 1));

endpackage

`default_nettype wire

/* src/fdbk_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module fdbk_regs import fdbk_pkg::*; (
	input logic clk,
	input logic rst,
	input logic lb_write,
	input logic [lb_addr_w-1:0] lb_addr,
	input logic signed [data_w-1:0] lb_data,
	output logic signed [data_w-1:0] set_i,
	output logic signed [data_w-1:0] set_q,
	output logic signed [data_w-1:0] gain_p,
	output logic signed [data_w-1:0] gain_i,
	output logic signed [data_w-1:0] lim_hi,
	output logic signed [data_w-1:0] lim_lo,
	output logic int_clr
);

	// Holding registers, all levels except the clear strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			set_i <= '0;
			set_q <= '0;
			gain_p <= '0;
			gain_i <= '0;
			lim_hi <= '0;
			lim_lo <= '0;
			int_clr <= 1'b0;
		end else begin
			// One-cycle pulse, no data stored
			int_clr <= lb_write && (lb_addr == addr_int_clr);
			if (lb_write) begin
				case (lb_addr)
					addr_set_i: set_i <= lb_data;
					addr_set_q: set_q <= lb_data;
					addr_gain_p: gain_p <= lb_data;
					addr_gain_i: gain_i <= lb_data;
					// Software keeps lim_lo at or below lim_hi
					addr_lim_hi: lim_hi <= lb_data;
					addr_lim_lo: lim_lo <= lb_data;
					// Unused addresses and the clear strobe are ignored here
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* src/iq_decim.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_decim import fdbk_pkg::*; (
	input logic clk,
	input logic rst,
	input logic sync,
	input logic iq,
	input logic signed [data_w-1:0] in_xy,
	output logic signed [data_w-1:0] avg_i,
	output logic signed [data_w-1:0] avg_q,
	output logic dec_stb
);

	// Zero on the cycle after sync, seven again when the next sync arrives
	logic [frame_cnt_w-1:0] cnt;
	// Set once a sync has been seen, so a partial first frame is dropped
	logic armed;
	logic frame_done;
	logic signed [sum_w-1:0] sum_i;
	logic signed [sum_w-1:0] sum_q;

	// A full frame ends when sync returns after the last slot
	assign frame_done = sync && armed && (cnt == frame_cnt_w'(frame_len - 1));

	// Control state
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			armed <= 1'b0;
			dec_stb <= 1'b0;
		end else begin
			dec_stb <= frame_done;
			if (sync) begin
				armed <= 1'b1;
				cnt <= '0;
			end else if (cnt != frame_cnt_w'(frame_len - 1)) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// Accumulators restart with the sync-cycle sample
	always_ff @(posedge clk) begin
		if (sync) begin
			sum_i <= iq ? sum_w'(in_xy) : '0;
			sum_q <= iq ? '0 : sum_w'(in_xy);
		end else if (iq) begin
			sum_i <= sum_i + in_xy;
		end else begin
			sum_q <= sum_q + in_xy;
		end
		// Divide by four, keep the top data_w bits
		if (frame_done) begin
			avg_i <= sum_i[sum_w-1 -: data_w];
			avg_q <= sum_q[sum_w-1 -: data_w];
		end
	end

endmodule

`default_nettype wire

/* src/iq_hold.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_hold import fdbk_pkg::*; (
	input logic clk,
	input logic rst,
	input logic sync,
	input logic iq,
	input logic drive_stb,
	input logic signed [data_w-1:0] drive_i,
	input logic signed [data_w-1:0] drive_q,
	input logic signed [data_w-1:0] set_i,
	input logic signed [data_w-1:0] set_q,
	output logic signed [data_w-1:0] drive_xy,
	output logic signed [data_w-1:0] set_xy
);

	// Pending drive, written whenever the integrator updates
	logic signed [data_w-1:0] pend_i;
	logic signed [data_w-1:0] pend_q;
	// Active frame values, only change on sync
	logic signed [data_w-1:0] act_i;
	logic signed [data_w-1:0] act_q;
	logic signed [data_w-1:0] act_set_i;
	logic signed [data_w-1:0] act_set_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			pend_i <= '0;
			pend_q <= '0;
		end else if (drive_stb) begin
			pend_i <= drive_i;
			pend_q <= drive_q;
		end
	end

	// Transfer at the frame boundary so one frame sees one drive
	// and one set-point, even if the bus writes mid-frame
	always_ff @(posedge clk) begin
		if (rst) begin
			act_i <= '0;
			act_q <= '0;
			act_set_i <= '0;
			act_set_q <= '0;
		end else if (sync) begin
			act_i <= pend_i;
			act_q <= pend_q;
			act_set_i <= set_i;
			act_set_q <= set_q;
		end
	end

	// Re-serialize to follow the interleaved input stream
	assign drive_xy = iq ? act_i : act_q;
	assign set_xy = iq ? act_set_i : act_set_q;

endmodule

`default_nettype wire

/* src/ll_prop.sv */
`timescale 1ns/1ps
`default_nettype none

module ll_prop import fdbk_pkg::*; (
	input logic clk,
	input logic rst,
	input logic signed [data_w-1:0] in_xy,
	input logic signed [data_w-1:0] set_xy,
	input logic signed [data_w-1:0] drive_xy,
	input logic signed [data_w-1:0] gain_p,
	input logic [1:0] coarse_scale,
	output logic signed [data_w-1:0] out_xy
);

	// One guard bit on the error
	logic signed [data_w:0] err;
	// Full product, no rounding before the shift
	logic signed [2*data_w:0] prod;
	// Shift shrinks as coarse_scale raises the loop gain
	logic [kp_shamt_w-1:0] shamt;
	logic signed [2*data_w+1:0] sum;
	logic signed [data_w-1:0] sat;

	assign err = set_xy - in_xy;
	assign prod = gain_p * err;
	assign shamt = kp_shamt_w'(kp_shift) - kp_shamt_w'(coarse_scale);

	// Slow-path drive plus fast proportional correction
	assign sum = drive_xy + (prod >>> shamt);

	// Clip to the signed output range
	always_comb begin
		if (sum > sat_max)
			sat = sat_max;
		else if (sum < sat_min)
			sat = sat_min;
		else
			sat = sum[data_w-1:0];
	end

	// Single registered stage, one cycle from in_xy
	always_ff @(posedge clk) begin
		if (rst)
			out_xy <= '0;
		else
			out_xy <= sat;
	end

endmodule

`default_nettype wire

/* src/slow_integ.sv */
`timescale 1ns/1ps
`default_nettype none

module slow_integ import fdbk_pkg::*; (
	input logic clk,
	input logic rst,
	input logic dec_stb,
	input logic signed [data_w-1:0] avg_i,
	input logic signed [data_w-1:0] avg_q,
	input logic signed [data_w-1:0] set_i,
	input logic signed [data_w-1:0] set_q,
	input logic signed [data_w-1:0] gain_i,
	input logic signed [data_w-1:0] lim_hi,
	input logic signed [data_w-1:0] lim_lo,
	input logic int_clr,
	output logic signed [data_w-1:0] drive_i,
	output logic signed [data_w-1:0] drive_q,
	output logic drive_stb
);

	// Error carries one extra bit so full-scale set minus sample cannot wrap
	logic signed [data_w:0] err_i;
	logic signed [data_w:0] err_q;
	logic signed [2*data_w:0] prod_i;
	logic signed [2*data_w:0] prod_q;
	logic stb1;
	// Unclamped next state, wide enough for any scaled product
	logic signed [2*data_w+1:0] next_i;
	logic signed [2*data_w+1:0] next_q;
	logic signed [acc_w-1:0] acc_i;
	logic signed [acc_w-1:0] acc_q;
	// Limits aligned to the top of the accumulator
	logic signed [acc_w-1:0] lim_hi_s;
	logic signed [acc_w-1:0] lim_lo_s;

	// Bound a wide sum to the scaled limit window
	function automatic logic signed [acc_w-1:0] clamp(
		input logic signed [2*data_w+1:0] v,
		input logic signed [acc_w-1:0] hi,
		input logic signed [acc_w-1:0] lo
	);
		if (v > hi)
			return hi;
		else if (v < lo)
			return lo;
		else
			return v[acc_w-1:0];
	endfunction

	assign err_i = set_i - avg_i;
	assign err_q = set_q - avg_q;
	assign lim_hi_s = {lim_hi, {(acc_w - data_w){1'b0}}};
	assign lim_lo_s = {lim_lo, {(acc_w - data_w){1'b0}}};

	// Stage 1: error times integral gain
	// Same gain serves both channels
	always_ff @(posedge clk) begin
		if (dec_stb) begin
			prod_i <= gain_i * err_i;
			prod_q <= gain_i * err_q;
		end
	end

	assign next_i = acc_i + (prod_i >>> ki_shift);
	assign next_q = acc_q + (prod_q >>> ki_shift);

	// Stage 2: accumulate and clamp, clear has priority
	always_ff @(posedge clk) begin
		if (rst || int_clr) begin
			acc_i <= '0;
			acc_q <= '0;
		end else if (stb1) begin
			acc_i <= clamp(next_i, lim_hi_s, lim_lo_s);
			acc_q <= clamp(next_q, lim_hi_s, lim_lo_s);
		end
	end

	// Strobe pipeline, drive_stb lands with the updated accumulator
	always_ff @(posedge clk) begin
		if (rst) begin
			stb1 <= 1'b0;
			drive_stb <= 1'b0;
		end else begin
			stb1 <= dec_stb;
			drive_stb <= stb1;
		end
	end

	assign drive_i = acc_i[acc_w-1 -: data_w];
	assign drive_q = acc_q[acc_w-1 -: data_w];

endmodule

`default_nettype wire

/* tb.f */
src/fdbk_pkg.sv
src/fdbk_regs.sv
src/iq_decim.sv
src/slow_integ.sv
src/iq_hold.sv
src/ll_prop.sv
src/fdbk_core.sv
verification/fdbk_core_checker.sv
verification/fdbk_core_tb.sv

/* verification/fdbk_core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fdbk_core_checker import fdbk_pkg::*; (
	input logic clk,
	input logic rst,
	input logic sync,
	input logic dec_stb,
	input logic signed [data_w-1:0] out_xy
);

	// Frame strobe keeps a fixed period
	sync_period: assert property (@(posedge clk) disable iff (rst) sync |-> ##frame_len sync)
		else $error("sync did not recur after frame_len cycles");

	// Output is zero through reset and on the first cycle computed after it
	reset_output: assert property (@(posedge clk)
		($past(rst) || $past(rst, 2)) |-> (out_xy == '0))
		else $error("out_xy nonzero during or right after reset");

	// Decimator strobes exactly one cycle after each sync that closes a full frame
	dec_after_sync: assert property (@(posedge clk) disable iff (rst)
		dec_stb == ($past(sync) && $past(sync, frame_len + 1) && !$past(rst, frame_len + 1)))
		else $error("dec_stb does not follow the sync that closes a frame");

endmodule

bind fdbk_core fdbk_core_checker frame_rules (
	.clk(clk), .rst(rst), .sync(sync), .dec_stb(dec_stb), .out_xy(out_xy)
);

`default_nettype wire

/* verification/fdbk_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fdbk_core_tb import fdbk_pkg::*; ();

	localparam int steps = 6;
	localparam int prop_samples = 32;
	localparam int drive_shift = acc_w - data_w;

	logic clk;
	logic rst;
	logic sync;
	logic iq;
	logic signed [data_w-1:0] in_xy;
	logic [1:0] coarse_scale;
	logic lb_write;
	logic [lb_addr_w-1:0] lb_addr;
	logic signed [data_w-1:0] lb_data;
	logic signed [data_w-1:0] out_xy;
	logic [frame_cnt_w-1:0] phase;
	logic [31:0] lcg_state;
	int errors;
	int checks;
	// Inputs of the cycle whose result out_xy shows now
	logic signed [data_w-1:0] prev_in;
	logic [1:0] prev_cs;
	logic prev_iq;
	// Expected drive ramp, row 0 is I and row 1 is Q
	longint ramp [0:1][0:steps];

	fdbk_core UUT (
		.clk(clk), .rst(rst), .sync(sync), .iq(iq), .in_xy(in_xy),
		.coarse_scale(coarse_scale), .lb_write(lb_write), .lb_addr(lb_addr),
		.lb_data(lb_data), .out_xy(out_xy)
	);

	always #2 clk = ~clk;

	// Frame generator, sync on slot 0 and I on even slots
	always @(posedge clk) begin
		sync <= (phase == '0);
		iq <= ~phase[0];
		phase <= phase + 1'b1;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic longint clip(input longint v, input longint hi, input longint lo);
		return (v > hi) ? hi : ((v < lo) ? lo : v);
	endfunction

	// Proportional rule, drive plus scaled gain times error, saturated
	function automatic longint prop_model(input longint x, input longint set, input longint drive,
			input longint gain, input int cs);
		longint p;
		p = (gain * (set - x)) >>> (kp_shift - cs);
		return clip(drive + p, (64'sd1 <<< (data_w - 1)) - 1, -(64'sd1 <<< (data_w - 1)));
	endfunction

	// One integrator update in accumulator units
	function automatic longint integ_model(input longint acc, input longint avg, input longint set,
			input longint gain, input longint hi, input longint lo);
		return clip(acc + ((gain * (set - avg)) >>> ki_shift),
			hi <<< drive_shift, lo <<< drive_shift);
	endfunction

	task automatic check_value(input longint exp, input longint got);
		checks++;
		if (got != exp) begin
			errors++;
			$display("Fail %0t out_xy expected %0d got %0d", $time, exp, got);
		end
	endtask

	task automatic bus_write(input logic [lb_addr_w-1:0] a, input longint d);
		@(posedge clk);
		lb_write <= 1'b1;
		lb_addr <= a;
		lb_data <= d[data_w-1:0];
		@(posedge clk);
		lb_write <= 1'b0;
	endtask

	// Counts sync pulses at the falling edge
	task automatic wait_syncs(input int n);
		int seen;
		int cnt;
		seen = 0;
		cnt = 0;
		while (seen < n && cnt < 2 * frame_len * n) begin
			@(negedge clk);
			cnt++;
			if (sync)
				seen++;
		end
		if (seen < n) begin
			errors++;
			$display("Timeout while waiting for sync pulses");
		end
	endtask

	// Drives one sample, then compares out_xy with the last cycle's model
	task automatic step_sample(input longint v, input logic [1:0] cs, input longint gain,
			input longint si, input longint sq, input bit check);
		@(posedge clk);
		in_xy <= v[data_w-1:0];
		coarse_scale <= cs;
		@(negedge clk);
		if (check)
			check_value(prop_model(prev_in, prev_iq ? si : sq, 0, gain, prev_cs), out_xy);
		prev_in = in_xy;
		prev_cs = coarse_scale;
		prev_iq = iq;
	endtask

	task automatic reset_state_zero;
		step_sample(0, 2'd0, 0, 0, 0, 1'b0);
		for (int k = 0; k < prop_samples; k++) begin
			lcg_state = lcg_next(lcg_state);
			step_sample(signed'(lcg_state[31 -: data_w]), 2'(k), 0, 0, 0, 1'b1);
		end
	endtask

	task automatic proportional_path;
		bus_write(addr_gain_p, 45000);
		bus_write(addr_set_i, 30000);
		bus_write(addr_set_q, -25000);
		wait_syncs(2);
		step_sample(0, 2'd0, 45000, 30000, -25000, 1'b0);
		for (int cs = 0; cs < 4; cs++) begin
			for (int k = 0; k < prop_samples; k++) begin
				lcg_state = lcg_next(lcg_state);
				step_sample(signed'(lcg_state[31 -: data_w]), 2'(cs), 45000, 30000, -25000, 1'b1);
			end
		end
	endtask

	task automatic saturation_limits;
		bus_write(addr_gain_p, 131071);
		bus_write(addr_set_i, 131071);
		bus_write(addr_set_q, 131071);
		wait_syncs(2);
		step_sample(-131072, 2'd0, 0, 0, 0, 1'b0);
		for (int k = 0; k < 16; k++) begin
			step_sample(-131072, 2'd3, 0, 0, 0, 1'b0);
			check_value(131071, out_xy);
		end
		bus_write(addr_set_i, -131072);
		bus_write(addr_set_q, -131072);
		wait_syncs(2);
		step_sample(131071, 2'd0, 0, 0, 0, 1'b0);
		for (int k = 0; k < 16; k++) begin
			step_sample(131071, 2'd0, 0, 0, 0, 1'b0);
			check_value(-131072, out_xy);
		end
	endtask

	task automatic integrator_ramp;
		longint acc [0:1];
		int idx [0:1];
		int c;
		int cnt;
		bus_write(addr_gain_i, 0);
		bus_write(addr_gain_p, 0);
		bus_write(addr_set_i, 20000);
		bus_write(addr_set_q, -12000);
		bus_write(addr_lim_hi, 131071);
		bus_write(addr_lim_lo, -131072);
		step_sample(1000, 2'd0, 0, 0, 0, 1'b0);
		bus_write(addr_int_clr, 0);
		wait_syncs(3);
		acc[0] = 0;
		acc[1] = 0;
		ramp[0][0] = 0;
		ramp[1][0] = 0;
		for (int k = 1; k <= steps; k++) begin
			acc[0] = integ_model(acc[0], 1000, 20000, 2000, 131071, -131072);
			acc[1] = integ_model(acc[1], 1000, -12000, 2000, 131071, -131072);
			ramp[0][k] = acc[0] >>> drive_shift;
			ramp[1][k] = acc[1] >>> drive_shift;
		end
		bus_write(addr_gain_i, 2000);
		idx[0] = 0;
		idx[1] = 0;
		cnt = 0;
		@(negedge clk);
		prev_iq = iq;
		while ((idx[0] < steps || idx[1] < steps) && cnt < 40 * frame_len) begin
			@(negedge clk);
			cnt++;
			c = prev_iq ? 0 : 1;
			checks++;
			// Either the value still held or the next one in the ramp
			if (idx[c] < steps && out_xy == ramp[c][idx[c] + 1]) begin
				idx[c]++;
			end else if (out_xy != ramp[c][idx[c]]) begin
				errors++;
				$display("Fail %0t out_xy expected %0d got %0d", $time, ramp[c][idx[c]], out_xy);
			end
			prev_iq = iq;
		end
		if (idx[0] < steps || idx[1] < steps) begin
			errors++;
			$display("Timeout while the integrator drive ramp was incomplete");
		end
	endtask

	task automatic clamp_and_clear;
		int held;
		int cnt;
		bus_write(addr_gain_i, 0);
		wait_syncs(1);
		bus_write(addr_int_clr, 0);
		bus_write(addr_lim_hi, 2000);
		bus_write(addr_lim_lo, -2000);
		wait_syncs(3);
		bus_write(addr_gain_i, 2000);
		held = 0;
		cnt = 0;
		@(negedge clk);
		prev_iq = iq;
		// I ramps up to lim_hi, Q down to lim_lo
		while (held < 2 * frame_len && cnt < 60 * frame_len) begin
			@(negedge clk);
			cnt++;
			checks++;
			if (prev_iq && out_xy > 2000) begin
				errors++;
				$display("Fail %0t out_xy expected at most 2000 got %0d", $time, out_xy);
			end else if (!prev_iq && out_xy < -2000) begin
				errors++;
				$display("Fail %0t out_xy expected at least -2000 got %0d", $time, out_xy);
			end
			if (prev_iq)
				held = (out_xy == 2000) ? held + 1 : 0;
			prev_iq = iq;
		end
		if (held < 2 * frame_len) begin
			errors++;
			$display("Timeout while waiting for the drive to settle at lim_hi");
		end
		bus_write(addr_gain_i, 0);
		wait_syncs(1);
		bus_write(addr_int_clr, 0);
		held = 0;
		cnt = 0;
		while (held < frame_len && cnt < 8 * frame_len) begin
			@(negedge clk);
			cnt++;
			held = (out_xy == 0) ? held + 1 : 0;
		end
		if (held < frame_len) begin
			errors++;
			$display("Timeout while waiting for out_xy to return to zero after clear");
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		sync = 1'b0;
		iq = 1'b0;
		phase = '0;
		in_xy = '0;
		coarse_scale = 2'd0;
		lb_write = 1'b0;
		lb_addr = '0;
		lb_data = '0;
		lcg_state = 32'h6ef2;
		errors = 0;
		checks = 0;
		prev_in = '0;
		prev_cs = 2'd0;
		prev_iq = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		reset_state_zero();
		proportional_path();
		saturation_limits();
		integrator_ramp();
		clamp_and_clear();
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
